/* bank_arbiter.sv */
//////////////////////////////
// host strobes are dropped while a job owns the banks
// host must watch host_wait and retry
//////////////////////////////

module bank_arbiter (
    input  logic                                    clk,
    input  logic                                    reset,
    input  logic                                    start,
    input  logic                                    done,
    input  logic                                    host_wr,
    input  logic                                    host_rd,
    input  logic [sa_pkg::lane_w-1:0]               host_lane,
    input  logic [sa_pkg::addr_w-1:0]               host_addr,
    input  logic [sa_pkg::data_w-1:0]               host_wdata,
    input  logic [sa_pkg::lanes-1:0]                rd_en,
    input  logic [sa_pkg::lanes*sa_pkg::addr_w-1:0] rd_addr,
    input  logic                                    row_we,
    input  logic [sa_pkg::addr_w-1:0]               row_addr,
    input  logic [sa_pkg::lanes*sa_pkg::data_w-1:0] row_data,
    input  logic [sa_pkg::lanes*sa_pkg::data_w-1:0] rd_data,
    output logic [sa_pkg::lanes-1:0]                mem_re,
    output logic [sa_pkg::lanes*sa_pkg::addr_w-1:0] mem_raddr,
    output logic [sa_pkg::lanes-1:0]                mem_we,
    output logic [sa_pkg::addr_w-1:0]               mem_waddr,
    output logic [sa_pkg::lanes*sa_pkg::data_w-1:0] mem_wdata,
    output logic [sa_pkg::data_w-1:0]               host_rdata,
    output logic                                    host_rvalid,
    output logic                                    host_wait,
    output logic                                    busy
);
    import sa_pkg::*;

    grant_t            grant;
    logic              job;
    logic [lanes-1:0]  host_sel;   // one-hot host lane
    logic [lane_w-1:0] rlane_q;    // lane of the pending host read

    assign job = (grant == grant_job);
    assign busy = job;
    assign host_wait = job;
    assign host_sel = lanes'(1) << host_lane;

    // job owns the banks from the start edge until done
    always_ff @(posedge clk) begin
        if (reset) begin
            grant <= grant_host;
        end else if (!job && start) begin
            grant <= grant_job;
        end else if (job && done) begin
            grant <= grant_host;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            host_rvalid <= 1'b0;
        end else begin
            host_rvalid <= host_rd && !job;
        end
    end

    always_ff @(posedge clk) begin
        if (host_rd && !job) begin
            rlane_q <= host_lane;
        end
    end

    assign host_rdata = rd_data[rlane_q*data_w +: data_w];

    always_comb begin
        if (job) begin
            mem_re = rd_en;
            mem_raddr = rd_addr;
            mem_we = {lanes{row_we}};    // result rows hit every lane
            mem_waddr = row_addr;
            mem_wdata = row_data;
        end else begin
            mem_re = host_rd ? host_sel : '0;
            mem_raddr = {lanes{host_addr}};
            mem_we = host_wr ? host_sel : '0;
            mem_waddr = host_addr;
            mem_wdata = {lanes{host_wdata}};
        end
    end

endmodule

/* bank_mem.sv */
//////////////////////////////
// one bank per lane, 1-cycle registered read
// read data holds when a lane is not enabled
//////////////////////////////

module bank_mem (
    input  logic                                    clk,
    input  logic [sa_pkg::lanes-1:0]                mem_re,
    input  logic [sa_pkg::lanes*sa_pkg::addr_w-1:0] mem_raddr,
    input  logic [sa_pkg::lanes-1:0]                mem_we,
    input  logic [sa_pkg::addr_w-1:0]               mem_waddr,
    input  logic [sa_pkg::lanes*sa_pkg::data_w-1:0] mem_wdata,
    output logic [sa_pkg::lanes*sa_pkg::data_w-1:0] rd_data
);
    import sa_pkg::*;

    for (genvar i = 0; i < lanes; i++) begin : g_bank
        logic [data_w-1:0] mem [mem_depth];
        logic [data_w-1:0] rdq;

        always_ff @(posedge clk) begin
            if (mem_we[i]) begin
                mem[mem_waddr] <= mem_wdata[i*data_w +: data_w];
            end
            // same-address read returns the old word
            if (mem_re[i]) begin
                rdq <= mem[mem_raddr[i*addr_w +: addr_w]];
            end
        end

        assign rd_data[i*data_w +: data_w] = rdq;
    end

endmodule

/* compile.f */
sa_pkg.sv
bank_mem.sv
bank_arbiter.sv
skew_reader.sv
pe_chain.sv
deskew_writer.sv
wavefront_top.sv
tb_wavefront.sv

/* deskew_writer.sv */
//////////////////////////////
// dst_base is latched at start; rows go to dst_base + k
// done pulses once, after the last row is written
//////////////////////////////

module deskew_writer (
    input  logic                                    clk,
    input  logic                                    reset,
    input  logic                                    start,
    input  logic [sa_pkg::addr_w-1:0]               dst_base,
    input  logic                                    wr_active,
    input  logic [sa_pkg::lanes*sa_pkg::data_w-1:0] sum_data,
    input  logic [sa_pkg::lanes-1:0]                sum_valid,
    output logic                                    row_we,
    output logic [sa_pkg::addr_w-1:0]               row_addr,
    output logic [sa_pkg::lanes*sa_pkg::data_w-1:0] row_data,
    output logic                                    done
);
    import sa_pkg::*;

    logic                    running;
    logic [addr_w-1:0]       dst_q;
    logic [lanes*data_w-1:0] al_data;    // one full row after deskew
    logic [lanes-1:0]        al_valid;
    logic                    stg_we;
    logic [lanes*data_w-1:0] stg_data;
    logic [lane_w-1:0]       row_cnt;

    // lane i waits lanes-1-i cycles for the last lane to catch up
    for (genvar i = 0; i < lanes; i++) begin : g_lane
        if (i == lanes - 1) begin : g_pass
            assign al_data[i*data_w +: data_w] = sum_data[i*data_w +: data_w];
            assign al_valid[i] = sum_valid[i];
        end else begin : g_delay
            logic [data_w-1:0]  dq [lanes-1-i];
            logic [lanes-2-i:0] vq;

            always_ff @(posedge clk) begin
                dq[0] <= sum_data[i*data_w +: data_w];
                for (int j = 1; j < lanes - 1 - i; j++) begin
                    dq[j] <= dq[j-1];
                end
            end

            always_ff @(posedge clk) begin
                if (reset) begin
                    vq <= '0;
                end else begin
                    vq[0] <= sum_valid[i];
                    for (int j = 1; j < lanes - 1 - i; j++) begin
                        vq[j] <= vq[j-1];
                    end
                end
            end

            assign al_data[i*data_w +: data_w] = dq[lanes-2-i];
            assign al_valid[i] = vq[lanes-2-i];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            running <= 1'b0;
            stg_we <= 1'b0;
            row_we <= 1'b0;
            row_cnt <= '0;
            done <= 1'b0;
        end else begin
            if (start && !running) begin
                running <= 1'b1;
            end else if (done) begin
                running <= 1'b0;
            end
            stg_we <= &al_valid;
            row_we <= stg_we;     // two stages keep the fixed job latency
            if (!wr_active) begin
                row_cnt <= '0;
            end else if (row_we) begin
                row_cnt <= row_cnt + 1'b1;
            end
            done <= row_we && (row_cnt == lane_w'(lanes - 1));
        end
    end

    always_ff @(posedge clk) begin
        if (start && !running) begin
            dst_q <= dst_base;
        end
        stg_data <= al_data;
        row_data <= stg_data;
    end

    assign row_addr = dst_q + addr_w'(row_cnt);

endmodule

/* pe_chain.sv */
//////////////////////////////
// running sums wrap modulo 256
// one register stage per lane
//////////////////////////////

module pe_chain (
    input  logic                                    clk,
    input  logic                                    reset,
    input  logic [sa_pkg::lanes-1:0]                rd_en,
    input  logic [sa_pkg::lanes*sa_pkg::data_w-1:0] rd_data,
    output logic [sa_pkg::lanes*sa_pkg::data_w-1:0] sum_data,
    output logic [sa_pkg::lanes-1:0]                sum_valid
);
    import sa_pkg::*;

    logic [lanes-1:0] data_vld;   // bank data valid, one cycle after rd_en

    always_ff @(posedge clk) begin
        if (reset) begin
            data_vld <= '0;
            sum_valid <= '0;
        end else begin
            data_vld <= rd_en;
            sum_valid <= data_vld;
        end
    end

    always_ff @(posedge clk) begin
        sum_data[0 +: data_w] <= rd_data[0 +: data_w];    // lane 0 starts the sum
        for (int i = 1; i < lanes; i++) begin
            // lane i-1 holds the same row here thanks to the skew
            sum_data[i*data_w +: data_w] <= rd_data[i*data_w +: data_w]
                                          + sum_data[(i-1)*data_w +: data_w];
        end
    end

endmodule

/* run.sh */
#!/bin/sh
# build and run with Verilator, pass only when the pass line shows up
verilator --binary --timing -Wno-fatal --top-module tb_wavefront -f compile.f \
    && ./obj_dir/Vtb_wavefront | tee /dev/stderr | grep -qx "Finished with no errors" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

/* sa_pkg.sv */
//////////////////////////////
// sizes are fixed for a 4 x 4 job of 8-bit words
// nothing here is meant to be varied per instance
//////////////////////////////

package sa_pkg;

    localparam int lanes = 4;         // lanes per job, also rows per job
    localparam int data_w = 8;        // stored word width
    localparam int addr_w = 8;        // bank address width
    localparam int lane_w = $clog2(lanes);
    localparam int mem_depth = 1 << addr_w;

    // read wavefront length, then the deskew tail
    localparam int job_cycles = 2 * lanes;
    localparam int job_latency = job_cycles + lanes;
    localparam int cnt_w = $clog2(job_latency);

    // skewed reader sequencing
    typedef enum logic {
        st_idle,
        st_sweep
    } reader_state_t;

    // owner of the bank ports
    typedef enum logic {
        grant_host,
        grant_job
    } grant_t;

endpackage

/* skew_reader.sv */
//////////////////////////////
// start is taken only when idle; sweep spans the whole job
// so a start during a running job is ignored
//////////////////////////////

module skew_reader (
    input  logic                                    clk,
    input  logic                                    reset,
    input  logic                                    start,
    input  logic [sa_pkg::addr_w-1:0]               src_base,
    output logic [sa_pkg::lanes-1:0]                rd_en,
    output logic [sa_pkg::lanes*sa_pkg::addr_w-1:0] rd_addr,
    output logic                                    wr_active
);
    import sa_pkg::*;

    reader_state_t     state;
    logic [cnt_w-1:0]  count;
    logic [addr_w-1:0] src_q;
    logic [addr_w-1:0] row_off [lanes];   // next row per lane

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= st_idle;
            count <= '0;
            rd_en <= '0;
        end else begin
            case (state)
                st_idle: begin
                    if (start) begin
                        state <= st_sweep;
                        count <= '0;
                        rd_en <= lanes'(1);    // lane 0, row 0 goes first
                    end
                end
                st_sweep: begin
                    count <= count + 1'b1;
                    // ones for lanes cycles, then zeros drain the diagonal
                    rd_en <= {rd_en[lanes-2:0], count < cnt_w'(lanes - 1)};
                    if (count == cnt_w'(job_latency - 1)) begin
                        state <= st_idle;
                        count <= '0;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == st_idle && start) begin
            src_q <= src_base;
            for (int i = 0; i < lanes; i++) begin
                row_off[i] <= '0;
            end
        end else begin
            for (int i = 0; i < lanes; i++) begin
                if (rd_en[i]) begin
                    row_off[i] <= row_off[i] + 1'b1;    // step once the row is read
                end
            end
        end
    end

    for (genvar i = 0; i < lanes; i++) begin : g_addr
        assign rd_addr[i*addr_w +: addr_w] = src_q + row_off[i];
    end

    // output side writes in the second half
    assign wr_active = (state == st_sweep) && (count >= cnt_w'(job_latency / 2));

endmodule

/* tb_wavefront.sv */
//////////////////////////////
// random words checked against a prefix-sum model
// all banks are filled through the host port first
//////////////////////////////

module tb_wavefront;
    timeunit 1ns;
    timeprecision 100ps;

    import sa_pkg::*;

    localparam int clk_period = 20;
    localparam int n_jobs = 6;
    localparam int n_host = 32;
    localparam int job_len = 2 * lanes + 4;   // start edge to done
    // fill, host test, then load, job window and readback for each job
    localparam int run_cycles = lanes * mem_depth + 2 * n_host
        + n_jobs * (lanes * lanes + 2 * job_len + 2 * lanes * lanes + 4) + 100;

    logic              clk = 1'b0;
    logic              reset;
    logic              start;
    logic [addr_w-1:0] src_base;
    logic [addr_w-1:0] dst_base;
    logic              host_wr;
    logic              host_rd;
    logic [lane_w-1:0] host_lane;
    logic [addr_w-1:0] host_addr;
    logic [data_w-1:0] host_wdata;
    logic [data_w-1:0] host_rdata;
    logic              host_rvalid;
    logic              host_wait;
    logic              busy;
    logic              done;

    logic [data_w-1:0] model [lanes][mem_depth];   // expected bank contents
    integer            seed = 2553;
    int                errors = 0;
    int                reads = 0;
    int                jobs = 0;

    always #(clk_period / 2) clk = ~clk;

    wavefront_top u_wavefront_top (
        .clk(clk), .reset(reset), .start(start), .src_base(src_base), .dst_base(dst_base),
        .host_wr(host_wr), .host_rd(host_rd), .host_lane(host_lane), .host_addr(host_addr),
        .host_wdata(host_wdata), .host_rdata(host_rdata), .host_rvalid(host_rvalid),
        .host_wait(host_wait), .busy(busy), .done(done)
    );

    // called on a falling edge while idle, so the write always lands
    task automatic host_write(input logic [lane_w-1:0] lane, input logic [addr_w-1:0] addr,
                              input logic [data_w-1:0] data);
        host_wr = 1'b1;
        host_lane = lane;
        host_addr = addr;
        host_wdata = data;
        @(negedge clk);
        host_wr = 1'b0;
        model[lane][addr] = data;
    endtask

    task automatic read_check(input logic [lane_w-1:0] lane, input logic [addr_w-1:0] addr);
        host_rd = 1'b1;
        host_lane = lane;
        host_addr = addr;
        @(negedge clk);
        host_rd = 1'b0;
        reads++;
        if (!host_rvalid) begin
            errors++;
            $display("error at %0t: no host_rvalid for lane %0d addr %02h", $time, lane, addr);
        end else if (host_rdata !== model[lane][addr]) begin
            errors++;
            $display("mismatch at %0t: lane %0d addr %02h got %02h expected %02h",
                     $time, lane, addr, host_rdata, model[lane][addr]);
        end
    endtask

    task automatic load_rows(input logic [addr_w-1:0] base);
        for (int k = 0; k < lanes; k++) begin
            for (int i = 0; i < lanes; i++) begin
                host_write(lane_w'(i), base + addr_w'(k), data_w'($random(seed)));
            end
        end
    endtask

    task automatic run_job(input logic [addr_w-1:0] src, input logic [addr_w-1:0] dst,
                           input bit contend);
        logic [data_w-1:0] sum;
        logic [data_w-1:0] res [lanes][lanes];
        logic [addr_w-1:0] a;
        logic [lane_w-1:0] c_lane;
        logic [addr_w-1:0] c_addr;
        int                cycles;
        bit                seen;
        // all reads finish before the first row write, so sums come from the old source
        for (int k = 0; k < lanes; k++) begin
            sum = '0;
            for (int i = 0; i < lanes; i++) begin
                a = src + addr_w'(k);
                sum = sum + model[i][a];
                res[k][i] = sum;
            end
        end
        c_lane = lane_w'($random(seed));
        // keep the dropped write clear of the result rows
        c_addr = dst + addr_w'(lanes) + addr_w'({$random(seed)} % (mem_depth - lanes));
        src_base = src;
        dst_base = dst;
        start = 1'b1;
        @(posedge clk);    // start edge
        cycles = 0;
        seen = 0;
        while (!seen && cycles < 4 * job_len) begin
            @(negedge clk);
            cycles++;
            start = 1'b0;
            host_wr = 1'b0;
            if (!busy) begin
                errors++;
                $display("error at %0t: busy low %0d cycles into the job", $time, cycles);
            end
            if (done) begin
                seen = 1;
            end else if (contend && cycles == 3) begin
                if (!host_wait) begin
                    errors++;
                    $display("error at %0t: host_wait low while busy", $time);
                end
                host_wr = 1'b1;    // must be dropped
                host_lane = c_lane;
                host_addr = c_addr;
                host_wdata = ~model[c_lane][c_addr];
                start = 1'b1;      // second start, must be ignored
                src_base = src + 8'h40;
                dst_base = dst + 8'h40;
            end
        end
        if (!seen) begin
            errors++;
            $display("error at %0t: done did not arrive within %0d cycles", $time, cycles);
        end else if (cycles != job_len) begin
            errors++;
            $display("mismatch at %0t: done after %0d cycles expected %0d",
                     $time, cycles, job_len);
        end
        @(negedge clk);
        if (done || busy) begin
            errors++;
            $display("error at %0t: done or busy still high after the done pulse", $time);
        end
        @(negedge clk);
        jobs++;
        for (int k = 0; k < lanes; k++) begin
            for (int i = 0; i < lanes; i++) begin
                a = dst + addr_w'(k);
                model[i][a] = res[k][i];
            end
        end
        for (int k = 0; k < lanes; k++) begin
            for (int i = 0; i < lanes; i++) begin
                read_check(lane_w'(i), dst + addr_w'(k));
                read_check(lane_w'(i), src + addr_w'(k));
            end
        end
        if (contend) begin
            read_check(c_lane, c_addr);
        end
    endtask

    initial begin
        logic [lane_w-1:0] t_lane [n_host];
        logic [addr_w-1:0] t_addr [n_host];
        logic [addr_w-1:0] src;
        logic [addr_w-1:0] dst;
        reset = 1'b1;
        start = 1'b0;
        src_base = '0;
        dst_base = '0;
        host_wr = 1'b0;
        host_rd = 1'b0;
        host_lane = '0;
        host_addr = '0;
        host_wdata = '0;
        repeat (5) @(negedge clk);
        reset = 1'b0;
        @(negedge clk);
        if (busy || done || host_wait || host_rvalid) begin
            errors++;
            $display("error at %0t: outputs not idle after reset", $time);
        end
        // whole memory gets random words so every read has a known value
        for (int i = 0; i < lanes; i++) begin
            for (int a = 0; a < mem_depth; a++) begin
                host_write(lane_w'(i), addr_w'(a), data_w'($random(seed)));
            end
        end
        for (int n = 0; n < n_host; n++) begin
            t_lane[n] = lane_w'($random(seed));
            t_addr[n] = addr_w'($random(seed));
            host_write(t_lane[n], t_addr[n], data_w'($random(seed)));
        end
        for (int n = 0; n < n_host; n++) begin
            read_check(t_lane[n], t_addr[n]);
        end
        load_rows(8'h10);
        run_job(8'h10, 8'h40, 0);
        load_rows(8'h20);
        run_job(8'h20, 8'h60, 1);
        for (int j = 0; j < n_jobs - 2; j++) begin
            src = addr_w'($random(seed));
            dst = addr_w'($random(seed));
            if (j == 0) begin
                src = 8'hfe;    // source wraps past the top
                dst = 8'h80;
            end else if (j == 1) begin
                src = 8'h30;
                dst = 8'hfd;    // result rows wrap
            end
            load_rows(src);
            run_job(src, dst, 0);
        end
        $display("jobs %0d, host reads %0d, errors %0d", jobs, reads, errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

    initial begin
        #(run_cycles * clk_period);
        $display("error: run did not finish within %0d cycles", run_cycles);
        $display("Finished with errors");
        $finish;
    end

endmodule

/* wavefront_top.sv */
//////////////////////////////
// job start to done is 2N+4 cycles
// host_wait is high for the whole job
//////////////////////////////

module wavefront_top (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        start,
    input  logic [sa_pkg::addr_w-1:0]   src_base,
    input  logic [sa_pkg::addr_w-1:0]   dst_base,
    input  logic                        host_wr,
    input  logic                        host_rd,
    input  logic [sa_pkg::lane_w-1:0]   host_lane,
    input  logic [sa_pkg::addr_w-1:0]   host_addr,
    input  logic [sa_pkg::data_w-1:0]   host_wdata,
    output logic [sa_pkg::data_w-1:0]   host_rdata,
    output logic                        host_rvalid,
    output logic                        host_wait,
    output logic                        busy,
    output logic                        done
);
    import sa_pkg::*;

    logic [lanes-1:0]        rd_en;
    logic [lanes*addr_w-1:0] rd_addr;
    logic                    wr_active;
    logic [lanes*data_w-1:0] rd_data;
    logic [lanes*data_w-1:0] sum_data;
    logic [lanes-1:0]        sum_valid;
    logic                    row_we;
    logic [addr_w-1:0]       row_addr;
    logic [lanes*data_w-1:0] row_data;
    logic [lanes-1:0]        mem_re;
    logic [lanes*addr_w-1:0] mem_raddr;
    logic [lanes-1:0]        mem_we;
    logic [addr_w-1:0]       mem_waddr;
    logic [lanes*data_w-1:0] mem_wdata;

    bank_mem u_mem (
        .clk(clk), .mem_re(mem_re), .mem_raddr(mem_raddr), .mem_we(mem_we),
        .mem_waddr(mem_waddr), .mem_wdata(mem_wdata), .rd_data(rd_data)
    );

    bank_arbiter u_arb (
        .clk(clk), .reset(reset), .start(start), .done(done),
        .host_wr(host_wr), .host_rd(host_rd), .host_lane(host_lane),
        .host_addr(host_addr), .host_wdata(host_wdata),
        .rd_en(rd_en), .rd_addr(rd_addr),
        .row_we(row_we), .row_addr(row_addr), .row_data(row_data),
        .rd_data(rd_data),
        .mem_re(mem_re), .mem_raddr(mem_raddr), .mem_we(mem_we),
        .mem_waddr(mem_waddr), .mem_wdata(mem_wdata),
        .host_rdata(host_rdata), .host_rvalid(host_rvalid),
        .host_wait(host_wait), .busy(busy)
    );

    skew_reader u_rd (
        .clk(clk), .reset(reset), .start(start), .src_base(src_base),
        .rd_en(rd_en), .rd_addr(rd_addr), .wr_active(wr_active)
    );

    pe_chain u_pe (
        .clk(clk), .reset(reset), .rd_en(rd_en), .rd_data(rd_data),
        .sum_data(sum_data), .sum_valid(sum_valid)
    );

    deskew_writer u_wr (
        .clk(clk), .reset(reset), .start(start), .dst_base(dst_base),
        .wr_active(wr_active), .sum_data(sum_data), .sum_valid(sum_valid),
        .row_we(row_we), .row_addr(row_addr), .row_data(row_data), .done(done)
    );

endmodule
